// File: design/death_control.sv
// death and restart fsm
`default_nettype none

module death_control (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     collision,
	input  wire game_pkg::keycode_t keycode,
	output logic                    dead,
	output logic                    restart
);
	import game_pkg::*;

	death_state_t state;
	death_state_t state_next;

	// ========================================
	// next state
	// ========================================
	always_comb begin
		state_next = state;
		case (state)
			st_alive:   if (collision) state_next = st_dead;
			st_dead:    if (keycode == key_enter) state_next = st_restart;
			st_restart: state_next = st_alive; // one clk only
			default:    state_next = st_alive;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_alive;
		else
			state <= state_next;
	end

	assign dead    = (state == st_dead);    // freezes motion
	assign restart = (state == st_restart); // sends sprites home

	// restart is a single clk strobe
	a_restart_pulse: assert property (@(posedge clk) disable iff (rst) restart |=> !restart);

endmodule

`default_nettype wire

// File: design/enemy_motion.sv
// bouncing enemy sprite
`default_nettype none

module enemy_motion #(
	parameter int h_active     = 640,
	parameter int v_active     = 480,
	parameter int enemy_size   = 16,
	parameter int enemy_step   = 2,
	parameter int start_x      = 40,
	parameter int start_y      = 40,
	parameter bit start_dx_neg = 1'b0, // 1 moves left
	parameter bit start_dy_neg = 1'b0  // 1 moves up
) (
	input  wire               clk,
	input  wire               rst,
	input  wire               frame_tick,
	input  wire               dead,
	input  wire               restart,
	output game_pkg::sprite_t enemy
);
	import video_pkg::*;

	localparam coord_t step = coord_t'(enemy_step);

	typedef struct packed {
		logic   neg; // direction, 1 is towards 0
		coord_t pos;
	} axis_t;

	axis_t ax_x;
	axis_t ax_y;

	// one axis, reverse when the next step would leave [0, lim]
	function automatic axis_t bounce(axis_t a, coord_t lim);
		axis_t r;
		if (a.neg) begin
			r = (a.pos < step) ? '{neg: 1'b0, pos: a.pos + step} : '{neg: 1'b1, pos: a.pos - step};
		end else begin
			r = (a.pos > lim - step) ? '{neg: 1'b1, pos: a.pos - step}
				: '{neg: 1'b0, pos: a.pos + step};
		end
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			ax_x <= '{neg: start_dx_neg, pos: coord_t'(start_x)};
			ax_y <= '{neg: start_dy_neg, pos: coord_t'(start_y)};
		end else if (frame_tick && !dead) begin
			ax_x <= bounce(ax_x, coord_t'(h_active - enemy_size));
			ax_y <= bounce(ax_y, coord_t'(v_active - enemy_size));
		end
	end

	assign enemy = '{x: ax_x.pos, y: ax_y.pos, size: coord_t'(enemy_size)};

endmodule

`default_nettype wire

// File: design/game_pkg.sv
// game level types
`default_nettype none

package game_pkg;

	// ========================================
	// keyboard
	// ========================================
	typedef logic [7:0] keycode_t; // usb hid usage id

	localparam keycode_t key_w     = 8'h1A; // up
	localparam keycode_t key_s     = 8'h16; // down
	localparam keycode_t key_a     = 8'h04; // left
	localparam keycode_t key_d     = 8'h07; // right
	localparam keycode_t key_enter = 8'h28; // restart after death

	// ========================================
	// sprites
	// ========================================
	// square sprite, x/y is the top left corner
	typedef struct packed {
		video_pkg::coord_t x;
		video_pkg::coord_t y;
		video_pkg::coord_t size; // side length
	} sprite_t;

	// ========================================
	// death fsm
	// ========================================
	typedef enum logic [1:0] {
		st_alive,   // normal play
		st_dead,    // frozen, waiting for enter
		st_restart  // one clk, sprites go home
	} death_state_t;

endpackage

`default_nettype wire

// File: design/game_top.sv
// sprite game core
`default_nettype none

module game_top #(
	parameter int h_active = 640, parameter int h_front = 16,
	parameter int h_sync   = 96,  parameter int h_back  = 48,
	parameter int v_active = 480, parameter int v_front = 10,
	parameter int v_sync   = 2,   parameter int v_back  = 33,
	parameter int player_size = 16,
	parameter int player_step = 4,
	parameter int enemy_size  = 16,
	parameter int enemy_step  = 2,
	parameter int e0_start_x = 40,  parameter int e0_start_y = 40,
	parameter bit e0_start_dx_neg = 1'b0, parameter bit e0_start_dy_neg = 1'b0,
	parameter int e1_start_x = 584, parameter int e1_start_y = 40,
	parameter bit e1_start_dx_neg = 1'b1, parameter bit e1_start_dy_neg = 1'b0
) (
	input  wire                     clk,
	input  wire                     rst,
	input  wire game_pkg::keycode_t keycode,
	output logic                    vga_hs,
	output logic                    vga_vs,
	output video_pkg::colour_t      vga_r,
	output video_pkg::colour_t      vga_g,
	output video_pkg::colour_t      vga_b,
	output logic                    dead
);
	import video_pkg::*;
	import game_pkg::*;

	logic      blank, pixel_en, frame_tick, collision, restart;
	draw_pos_t draw_pos;
	sprite_t   player, enemy0, enemy1;

	vga_timing #(.h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
		.v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)) vga_0 (
		.clk(clk), .rst(rst), .vga_hs(vga_hs), .vga_vs(vga_vs), .blank(blank),
		.pixel_en(pixel_en), .frame_tick(frame_tick), .draw_pos(draw_pos));

	player_motion #(.h_active(h_active), .v_active(v_active), .player_size(player_size),
		.player_step(player_step)) player_0 (.clk(clk), .rst(rst), .frame_tick(frame_tick),
		.dead(dead), .restart(restart), .keycode(keycode), .player(player));

	// ======================================== enemies
	enemy_motion #(.h_active(h_active), .v_active(v_active), .enemy_size(enemy_size),
		.enemy_step(enemy_step), .start_x(e0_start_x), .start_y(e0_start_y),
		.start_dx_neg(e0_start_dx_neg), .start_dy_neg(e0_start_dy_neg)) enemy_0 (
		.clk(clk), .rst(rst), .frame_tick(frame_tick), .dead(dead), .restart(restart),
		.enemy(enemy0));

	enemy_motion #(.h_active(h_active), .v_active(v_active), .enemy_size(enemy_size),
		.enemy_step(enemy_step), .start_x(e1_start_x), .start_y(e1_start_y),
		.start_dx_neg(e1_start_dx_neg), .start_dy_neg(e1_start_dy_neg)) enemy_1 (
		.clk(clk), .rst(rst), .frame_tick(frame_tick), .dead(dead), .restart(restart),
		.enemy(enemy1));

	pixel_mapper mapper_0 (.clk(clk), .rst(rst), .pixel_en(pixel_en), .blank(blank),
		.dead(dead), .draw_pos(draw_pos), .player(player), .enemy0(enemy0), .enemy1(enemy1),
		.rgb({vga_r, vga_g, vga_b}), .collision(collision)); // red in the top nibble

	death_control death_0 (.clk(clk), .rst(rst), .collision(collision), .keycode(keycode),
		.dead(dead), .restart(restart));

endmodule

`default_nettype wire

// File: design/pixel_mapper.sv
// sprite painter and contact detect
`default_nettype none

module pixel_mapper (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       pixel_en,
	input  wire                       blank,
	input  wire                       dead,
	input  wire video_pkg::draw_pos_t draw_pos,
	input  wire game_pkg::sprite_t    player,
	input  wire game_pkg::sprite_t    enemy0,
	input  wire game_pkg::sprite_t    enemy1,
	output video_pkg::rgb_t           rgb,
	output logic                      collision
);
	import video_pkg::*;
	import game_pkg::*;

	logic on_player;
	logic on_enemy;
	logic hit;      // overlap on a visible pixel
	logic at_origin;
	logic hit_seen; // already reported this frame
	rgb_t colour;

	// half open box test, size pixels wide
	function automatic logic in_box(draw_pos_t p, sprite_t s);
		return (p.x >= s.x) && (p.x < s.x + s.size) && (p.y >= s.y) && (p.y < s.y + s.size);
	endfunction

	assign on_player = in_box(draw_pos, player);
	assign on_enemy  = in_box(draw_pos, enemy0) || in_box(draw_pos, enemy1);
	assign hit       = !blank && !dead && on_player && on_enemy;
	assign at_origin = (draw_pos.x == '0) && (draw_pos.y == '0);

	// player over enemy over background
	always_comb begin
		if (blank)
			colour = col_black;
		else if (on_player)
			colour = dead ? col_player_dead : col_player;
		else if (on_enemy)
			colour = col_enemy;
		else
			colour = col_background;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rgb       <= col_black;
			collision <= 1'b0;
			hit_seen  <= 1'b0;
		end else begin
			collision <= 1'b0; // single clk pulse
			if (pixel_en) begin
				rgb <= colour;
				if (hit && (!hit_seen || at_origin)) begin
					collision <= 1'b1;
					hit_seen  <= 1'b1;
				end else if (at_origin) begin
					hit_seen <= 1'b0; // new frame, rearm
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/player_motion.sv
// keyboard driven player sprite
`default_nettype none

module player_motion #(
	parameter int h_active    = 640,
	parameter int v_active    = 480,
	parameter int player_size = 16,
	parameter int player_step = 4
) (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 frame_tick,
	input  wire                 dead,
	input  wire                 restart,
	input  wire game_pkg::keycode_t keycode,
	output game_pkg::sprite_t   player
);
	import video_pkg::*;
	import game_pkg::*;

	localparam coord_t x_max   = coord_t'(h_active - player_size); // right clamp
	localparam coord_t y_max   = coord_t'(v_active - player_size); // bottom clamp
	localparam coord_t x_home  = coord_t'((h_active - player_size) / 2);
	localparam coord_t y_home  = coord_t'((v_active - player_size) / 2);
	localparam coord_t step    = coord_t'(player_step);

	coord_t pos_x;
	coord_t pos_y;
	coord_t next_x;
	coord_t next_y;

	// one step per frame, saturating at the screen edge
	always_comb begin
		next_x = pos_x;
		next_y = pos_y;
		case (keycode)
			key_d: next_x = (pos_x > x_max - step) ? x_max : pos_x + step;
			key_a: next_x = (pos_x < step) ? '0 : pos_x - step;
			key_s: next_y = (pos_y > y_max - step) ? y_max : pos_y + step;
			key_w: next_y = (pos_y < step) ? '0 : pos_y - step;
			default: ; // other keys do nothing
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			pos_x <= x_home; // back to centre
			pos_y <= y_home;
		end else if (frame_tick && !dead) begin
			pos_x <= next_x;
			pos_y <= next_y;
		end
	end

	assign player = '{x: pos_x, y: pos_y, size: coord_t'(player_size)};

	// sprite fully on screen at all times
	a_on_screen: assert property (@(posedge clk) disable iff (rst)
		(player.x <= x_max) && (player.y <= y_max));

endmodule

`default_nettype wire

// File: design/vga_timing.sv
// vga timing generator
`default_nettype none

module vga_timing #(
	parameter int h_active = 640,
	parameter int h_front  = 16,
	parameter int h_sync   = 96,
	parameter int h_back   = 48,
	parameter int v_active = 480,
	parameter int v_front  = 10,
	parameter int v_sync   = 2,
	parameter int v_back   = 33
) (
	input  wire                  clk,
	input  wire                  rst,
	output logic                 vga_hs,
	output logic                 vga_vs,
	output logic                 blank,
	output logic                 pixel_en,
	output logic                 frame_tick,
	output video_pkg::draw_pos_t draw_pos
);
	import video_pkg::*;

	// counter limits, all in pixel_en units
	localparam coord_t h_last   = coord_t'(h_active + h_front + h_sync + h_back - 1);
	localparam coord_t v_last   = coord_t'(v_active + v_front + v_sync + v_back - 1);
	localparam coord_t hs_first = coord_t'(h_active + h_front);
	localparam coord_t hs_after = coord_t'(h_active + h_front + h_sync);
	localparam coord_t vs_first = coord_t'(v_active + v_front);
	localparam coord_t vs_after = coord_t'(v_active + v_front + v_sync);

	coord_t h_cnt;
	coord_t v_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			pixel_en <= 1'b0;
			h_cnt    <= '0;
			v_cnt    <= '0;
		end else begin
			pixel_en <= ~pixel_en; // half rate pixel strobe
			if (pixel_en) begin
				if (h_cnt == h_last) begin
					h_cnt <= '0;
					v_cnt <= (v_cnt == v_last) ? '0 : v_cnt + 1'b1; // next line or wrap
				end else begin
					h_cnt <= h_cnt + 1'b1;
				end
			end
		end
	end

	assign vga_hs     = ~((h_cnt >= hs_first) && (h_cnt < hs_after)); // active low
	assign vga_vs     = ~((v_cnt >= vs_first) && (v_cnt < vs_after));
	assign blank      = (h_cnt >= coord_t'(h_active)) || (v_cnt >= coord_t'(v_active));
	assign frame_tick = pixel_en && (h_cnt == h_last) && (v_cnt == v_last); // wrap to 0,0
	assign draw_pos   = '{x: h_cnt, y: v_cnt};

	// strobe never stretches over two clks
	a_pe_gap: assert property (@(posedge clk) disable iff (rst) pixel_en |=> !pixel_en);
	// both counters back at the origin right after the tick
	a_tick_wrap: assert property (@(posedge clk) disable iff (rst)
		frame_tick |=> (h_cnt == '0) && (v_cnt == '0));

endmodule

`default_nettype wire

// File: design/video_pkg.sv
// video types and colours
`default_nettype none

package video_pkg;

	// ========================================
	// screen geometry
	// ========================================
	typedef logic [9:0] coord_t;  // x or y on screen, up to 1023
	typedef logic [3:0] colour_t; // one dac channel

	typedef struct packed {
		colour_t red;
		colour_t green;
		colour_t blue;
	} rgb_t; // 12 bit pixel

	typedef struct packed {
		coord_t x;
		coord_t y;
	} draw_pos_t; // pixel being scanned out

	// ========================================
	// palette
	// ========================================
	localparam rgb_t col_background  = '{red: 4'd1, green: 4'd1, blue: 4'd4};
	localparam rgb_t col_player      = '{red: 4'd0, green: 4'd15, blue: 4'd0};
	localparam rgb_t col_player_dead = '{red: 4'd15, green: 4'd15, blue: 4'd15};
	localparam rgb_t col_enemy       = '{red: 4'd15, green: 4'd0, blue: 4'd0};
	localparam rgb_t col_black       = '{red: 4'd0, green: 4'd0, blue: 4'd0};

endpackage

`default_nettype wire

// File: sim/game_tb.sv
// sprite game core testbench
`default_nettype none

module game_tb;
	localparam logic [11:0] c_bg   = 12'h114;
	localparam logic [11:0] c_pl   = 12'h0F0;
	localparam logic [11:0] c_dead = 12'hFFF;
	localparam logic [11:0] c_en   = 12'hF00;
	localparam logic [11:0] c_blk  = 12'h000;

	logic clk, rst;
	logic [7:0] keycode;
	wire vga_hs, vga_vs, dead;
	wire [3:0] vga_r, vga_g, vga_b;
	int errors = 0;
	int checks = 0;
	int px, py;                       // player model
	int ex[2], ey[2];                 // enemy models
	bit exn[2], eyn[2];               // 1 is towards 0
	logic [11:0] frame [0:23][0:39];  // one captured frame, 40 positions per line
	logic [11:0] held  [0:23][0:39];

	game_top #(.h_active(32), .h_front(2), .h_sync(4), .h_back(2),
		.v_active(24), .v_front(1), .v_sync(2), .v_back(1),
		.player_size(4), .player_step(2), .enemy_size(4), .enemy_step(1),
		.e0_start_x(2), .e0_start_y(2), .e0_start_dx_neg(1'b0), .e0_start_dy_neg(1'b0),
		.e1_start_x(26), .e1_start_y(2), .e1_start_dx_neg(1'b1), .e1_start_dy_neg(1'b0)
	) dut0 (.clk(clk), .rst(rst), .keycode(keycode), .vga_hs(vga_hs), .vga_vs(vga_vs),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .dead(dead));

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// reference model
	// ========================================
	task automatic reset_model();
		px = 14; // centre of 32x24 for a 4 wide sprite
		py = 10;
		ex[0] = 2;
		ey[0] = 2;
		exn[0] = 0;
		eyn[0] = 0;
		ex[1] = 26;
		ey[1] = 2;
		exn[1] = 1;
		eyn[1] = 0;
	endtask

	task automatic step_axis(inout int p, inout bit neg, input int lim);
		if (neg && p - 1 < 0) begin
			neg = 0; // bounce off 0
			p = p + 1;
		end else if (!neg && p + 1 > lim) begin
			neg = 1; // bounce off far edge
			p = p - 1;
		end else
			p = neg ? p - 1 : p + 1;
	endtask

	task automatic advance_model(input logic [7:0] k);
		case (k)
			8'h07: px = (px + 2 > 28) ? 28 : px + 2;
			8'h04: px = (px - 2 < 0) ? 0 : px - 2;
			8'h16: py = (py + 2 > 20) ? 20 : py + 2;
			8'h1A: py = (py - 2 < 0) ? 0 : py - 2;
			default: ;
		endcase
		for (int i = 0; i < 2; i++) begin
			step_axis(ex[i], exn[i], 28);
			step_axis(ey[i], eyn[i], 20);
		end
	endtask

	function automatic bit inside_box(int x, int y, int bx, int by);
		return (x >= bx) && (x < bx + 4) && (y >= by) && (y < by + 4);
	endfunction

	// ========================================
	// capture and compare
	// ========================================
	task automatic sync_while(input bit use_vs, input bit level, output int n);
		n = 0;
		while (((use_vs ? vga_vs : vga_hs) == level) && n < 5000) begin
			@(negedge clk);
			n++;
		end
		if (n >= 5000) begin
			errors++;
			$display("timeout: %s stuck at %0b", use_vs ? "vs" : "hs", level);
		end
	endtask

	task automatic capture_frame();
		int n;
		sync_while(1, 1, n);
		sync_while(1, 0, n); // now on line 27, pixel 0, first clk
		repeat (80) @(negedge clk); // rest of line 27
		for (int y = 0; y < 24; y++)
			for (int x = 0; x < 40; x++) begin
				repeat (2) @(negedge clk); // rgb lags one clk behind pixel_en
				frame[y][x] = {vga_r, vga_g, vga_b};
			end
	endtask

	task automatic check_frame(input string name, input bit dead_exp);
		logic [11:0] want;
		int bad;
		bad = 0;
		checks++;
		if (dead !== dead_exp) begin
			errors++;
			$display("MISMATCH %s dead expected %0b actual %0b", name, dead_exp, dead);
		end
		for (int y = 0; y < 24; y++)
			for (int x = 0; x < 40; x++) begin
				if (x >= 32) want = c_blk;
				else if (inside_box(x, y, px, py)) want = dead_exp ? c_dead : c_pl;
				else if (inside_box(x, y, ex[0], ey[0]) || inside_box(x, y, ex[1], ey[1]))
					want = c_en;
				else want = c_bg;
				if (frame[y][x] !== want) begin
					errors++;
					bad++;
					if (bad <= 4)
						$display("MISMATCH %s (%0d,%0d) expected %h actual %h",
							name, x, y, want, frame[y][x]);
				end
			end
	endtask

	task automatic hold_key(input string name, input logic [7:0] k, input int frames);
		@(posedge clk);
		keycode <= k;
		repeat (frames) begin
			capture_frame();
			advance_model(k);
			check_frame(name, 0);
		end
	endtask

	// ========================================
	// tests
	// ========================================
	task automatic sync_timing();
		int lo, hi;
		checks++;
		if (dead !== 1'b0) begin
			errors++;
			$display("MISMATCH timing dead expected 0 actual %0b", dead);
		end
		sync_while(1, 0, lo);
		sync_while(1, 1, hi);
		sync_while(1, 0, lo); // vs low clks
		sync_while(1, 1, hi);
		checks++;
		if (lo != 160) begin
			errors++;
			$display("MISMATCH timing vs_low expected 160 actual %0d", lo);
		end
		checks++;
		if (lo + hi != 2240) begin
			errors++;
			$display("MISMATCH timing frame expected 2240 actual %0d", lo + hi);
		end
		sync_while(0, 1, hi);
		sync_while(0, 0, lo);
		sync_while(0, 1, hi);
		checks++;
		if (lo != 8) begin
			errors++;
			$display("MISMATCH timing hs_low expected 8 actual %0d", lo);
		end
		checks++;
		if (lo + hi != 80) begin
			errors++;
			$display("MISMATCH timing line expected 80 actual %0d", lo + hi);
		end
	endtask

	task automatic die_and_freeze();
		int n, white, green, diff;
		@(posedge clk);
		keycode <= 8'h16; // walk down into the enemy coming up
		n = 0;
		while (!dead && n < 20 * 2240) begin
			@(negedge clk);
			n++;
		end
		if (!dead) begin
			errors++;
			$display("timeout: dead never rose after steering into enemy");
		end
		@(posedge clk);
		keycode <= 8'h00;
		capture_frame();
		white = 0;
		green = 0;
		for (int y = 0; y < 24; y++)
			for (int x = 0; x < 40; x++) begin
				held[y][x] = frame[y][x];
				white += (frame[y][x] === c_dead);
				green += (frame[y][x] === c_pl);
			end
		checks++;
		if (white != 16) begin
			errors++;
			$display("MISMATCH death white_pixels expected 16 actual %0d", white);
		end
		checks++;
		if (green != 0) begin
			errors++;
			$display("MISMATCH death green_pixels expected 0 actual %0d", green);
		end
		repeat (3) begin
			capture_frame();
			diff = 0;
			for (int y = 0; y < 24; y++)
				for (int x = 0; x < 40; x++)
					if (frame[y][x] !== held[y][x])
						diff++;
			checks++;
			if (diff != 0) begin
				errors++;
				$display("frozen frame changed at %0d positions while dead was high", diff);
			end
			checks++;
			if (dead !== 1'b1) begin
				errors++;
				$display("MISMATCH freeze dead expected 1 actual %0b", dead);
			end
		end
	endtask

	task automatic restart_after_enter();
		int n;
		@(posedge clk);
		keycode <= 8'h28;
		n = 0;
		while (dead && n < 100) begin
			@(negedge clk);
			n++;
		end
		if (dead) begin
			errors++;
			$display("timeout: dead stayed high after enter");
		end
		@(posedge clk);
		keycode <= 8'h00;
		reset_model();
		capture_frame();
		advance_model(8'h00); // one frame tick before the captured frame
		check_frame("restart", 0);
	endtask

	initial begin
		rst = 1'b1;
		keycode = 8'h00;
		reset_model();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		sync_timing();
		advance_model(8'h00); // the vs measurement spans one frame wrap
		hold_key("move_s", 8'h16, 1);
		hold_key("move_w", 8'h1A, 7);
		hold_key("move_d", 8'h07, 8);
		hold_key("move_a", 8'h04, 4);
		hold_key("other_key", 8'h05, 3);
		hold_key("bounce", 8'h00, 7);
		die_and_freeze();
		restart_after_enter();
		$display("checks=%0d errors=%0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
design/video_pkg.sv
design/game_pkg.sv
design/vga_timing.sv
design/player_motion.sv
design/enemy_motion.sv
design/pixel_mapper.sv
design/death_control.sv
design/game_top.sv
sim/game_tb.sv
